/* include/present_params.svh */
// ========================================================================
// PRESENT-80 sizes. These are fixed by the cipher and are not tunable.
// ========================================================================
`ifndef PRESENT_PARAMS_SVH
`define PRESENT_PARAMS_SVH

// one data block, and also one round key.
`define PRESENT_BLOCK_W 64

`define PRESENT_KEY_W 80    // master key and key register width.

`define PRESENT_NIBBLE_W 4  // s-box input and output width.

// whitening key plus one key per round.
`define PRESENT_NUM_RK 32

`define PRESENT_RK_IDX_W 5  // wide enough to count 0..31.

`endif

/* hdl/present_pkg.sv */
// ========================================================================
// Data types and the PRESENT round primitives, all combinational.
// ========================================================================
`include "present_params.svh"

package present_pkg;

    typedef logic [`PRESENT_BLOCK_W-1:0]  block_t;
    typedef logic [`PRESENT_KEY_W-1:0]    key_t;
    typedef logic [`PRESENT_RK_IDX_W-1:0] rk_idx_t;
    typedef logic [`PRESENT_NIBBLE_W-1:0] nibble_t;

    localparam int NIBBLES  = `PRESENT_BLOCK_W / `PRESENT_NIBBLE_W;
    localparam int P_STRIDE = `PRESENT_BLOCK_W / 4;  // bit spacing of the permutation.

    function automatic nibble_t sbox_f(nibble_t x);
        nibble_t y;
        case (x)
            4'h0: y = 4'hC;
            4'h1: y = 4'h5;
            4'h2: y = 4'h6;
            4'h3: y = 4'hB;
            4'h4: y = 4'h9;
            4'h5: y = 4'h0;
            4'h6: y = 4'hA;
            4'h7: y = 4'hD;
            4'h8: y = 4'h3;
            4'h9: y = 4'hE;
            4'hA: y = 4'hF;
            4'hB: y = 4'h8;
            4'hC: y = 4'h4;
            4'hD: y = 4'h7;
            4'hE: y = 4'h1;
            default: y = 4'h2;
        endcase
        return y;
    endfunction

    function automatic nibble_t sbox_inv_f(nibble_t x);
        nibble_t y;
        case (x)
            4'h0: y = 4'h5;
            4'h1: y = 4'hE;
            4'h2: y = 4'hF;
            4'h3: y = 4'h8;
            4'h4: y = 4'hC;
            4'h5: y = 4'h1;
            4'h6: y = 4'h2;
            4'h7: y = 4'hD;
            4'h8: y = 4'hB;
            4'h9: y = 4'h4;
            4'hA: y = 4'h6;
            4'hB: y = 4'h3;
            4'hC: y = 4'h0;
            4'hD: y = 4'h7;
            4'hE: y = 4'h9;
            default: y = 4'hA;
        endcase
        return y;
    endfunction

    function automatic block_t s_layer_f(block_t b);
        block_t res;
        for (int i = 0; i < NIBBLES; i++) begin
            res[i*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W] =
                sbox_f(b[i*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W]);
        end
        return res;
    endfunction

    function automatic block_t s_layer_inv_f(block_t b);
        block_t res;
        for (int i = 0; i < NIBBLES; i++) begin
            res[i*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W] =
                sbox_inv_f(b[i*`PRESENT_NIBBLE_W +: `PRESENT_NIBBLE_W]);
        end
        return res;
    endfunction

    // bit i moves to 16*(i mod 4) + i/4; bit 63 maps onto itself.
    function automatic block_t p_layer_f(block_t b);
        block_t res;
        for (int i = 0; i < `PRESENT_BLOCK_W; i++) begin
            res[P_STRIDE * (i % 4) + i / 4] = b[i];
        end
        return res;
    endfunction

    function automatic block_t p_layer_inv_f(block_t b);
        block_t res;
        for (int i = 0; i < `PRESENT_BLOCK_W; i++) begin
            res[i] = b[P_STRIDE * (i % 4) + i / 4];
        end
        return res;
    endfunction

endpackage

/* hdl/present_key_schedule.sv */
// ========================================================================
// Round keys are generated one per cycle after a key is accepted.
// rk_o is only meaningful once key_done_o is high.
// ========================================================================
`include "present_params.svh"

module present_key_schedule (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 key_valid_i,
    input  present_pkg::key_t    key_i,
    input  logic                 engine_idle_i,
    input  present_pkg::rk_idx_t rk_idx_i,
    output logic                 key_ready_o,
    output logic                 key_done_o,
    output present_pkg::block_t  rk_o
);
    import present_pkg::*;

    typedef enum logic [1:0] {
        KS_EMPTY,  // no key loaded since reset.
        KS_GEN,    // writing one round key per cycle.
        KS_WRAP,   // last key written, done follows.
        KS_DONE
    } ks_state_t;

    ks_state_t ks_state;
    key_t      key_reg;
    key_t      key_rot;
    key_t      key_upd;
    rk_idx_t   rk_cnt;
    rk_idx_t   rk_cnt_nxt;
    logic      key_fire;
    block_t    rk_mem [`PRESENT_NUM_RK];

    // ====================================================================
    // handshake and status
    // ====================================================================
    assign key_ready_o = ((ks_state == KS_EMPTY) || (ks_state == KS_DONE)) && engine_idle_i;
    assign key_done_o  = (ks_state == KS_DONE);
    assign key_fire    = key_valid_i && key_ready_o;

    // ====================================================================
    // key register update
    // ====================================================================
    assign rk_cnt_nxt = rk_cnt + 1'b1;  // the update that yields key n uses n.

    always_comb begin
        key_rot = {key_reg[18:0], key_reg[79:19]};  // rotate left by 61.
        key_upd = {sbox_f(key_rot[79:76]),
                   key_rot[75:20],
                   key_rot[19:15] ^ rk_cnt_nxt,
                   key_rot[14:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ks_state <= KS_EMPTY;
            rk_cnt   <= '0;
        end else begin
            case (ks_state)
                KS_GEN: begin
                    rk_cnt <= rk_cnt_nxt;
                    if (rk_cnt == rk_idx_t'(`PRESENT_NUM_RK - 1)) begin
                        ks_state <= KS_WRAP;
                    end
                end
                KS_WRAP: begin
                    ks_state <= KS_DONE;
                end
                default: begin
                    // a new key may replace an old schedule.
                    if (key_fire) begin
                        ks_state <= KS_GEN;
                        rk_cnt   <= '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (key_fire) begin
            key_reg <= key_i;
        end else if (ks_state == KS_GEN) begin
            key_reg <= key_upd;
        end
    end

    // ====================================================================
    // round-key memory
    // ====================================================================
    // round key n is the top 64 bits of the register after n updates.
    always_ff @(posedge clk) begin
        if (ks_state == KS_GEN) begin
            rk_mem[rk_cnt] <= key_reg[`PRESENT_KEY_W-1 -: `PRESENT_BLOCK_W];
        end
    end

    assign rk_o = rk_mem[rk_idx_i];

endmodule

/* hdl/present_round_engine.sv */
// ========================================================================
// One block at a time: whitening plus 31 rounds, one step per cycle.
// Blocks are taken only after the round keys are complete.
// ========================================================================
`include "present_params.svh"

module present_round_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 blk_valid_i,
    input  present_pkg::block_t  blk_i,
    input  logic                 dec_i,
    input  logic                 keys_done_i,
    input  present_pkg::block_t  rk_i,
    input  logic                 core_ready_i,
    output logic                 blk_ready_o,
    output logic                 idle_o,
    output present_pkg::rk_idx_t rk_idx_o,
    output logic                 core_valid_o,
    output present_pkg::block_t  core_data_o
);
    import present_pkg::*;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_RUN,
        ENG_HOLD  // result waits for the buffer.
    } eng_state_t;

    eng_state_t eng_state;
    block_t     blk_q;
    block_t     round_in;
    block_t     blk_nxt;
    logic       dec_q;
    rk_idx_t    rnd_cnt;
    logic       blk_fire;

    assign idle_o       = (eng_state == ENG_IDLE);
    assign blk_ready_o  = idle_o && keys_done_i;
    assign blk_fire     = blk_valid_i && blk_ready_o;
    assign core_valid_o = (eng_state == ENG_HOLD);
    assign core_data_o  = blk_q;

    // decryption walks the keys from 31 down to 0, and ~cnt is 31 - cnt.
    assign rk_idx_o = dec_q ? ~rnd_cnt : rnd_cnt;

    // ====================================================================
    // round datapath
    // ====================================================================
    always_comb begin
        if (rnd_cnt == '0) begin
            round_in = blk_q;  // whitening step is the key xor alone.
        end else if (dec_q) begin
            round_in = s_layer_inv_f(p_layer_inv_f(blk_q));
        end else begin
            round_in = p_layer_f(s_layer_f(blk_q));
        end
        blk_nxt = round_in ^ rk_i;
    end

    always_ff @(posedge clk) begin
        if (blk_fire) begin
            blk_q <= blk_i;
            dec_q <= dec_i;
        end else if (eng_state == ENG_RUN) begin
            blk_q <= blk_nxt;
        end
    end

    // ====================================================================
    // control
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            eng_state <= ENG_IDLE;
            rnd_cnt   <= '0;
        end else begin
            case (eng_state)
                ENG_RUN: begin
                    rnd_cnt <= rnd_cnt + 1'b1;
                    if (rnd_cnt == rk_idx_t'(`PRESENT_NUM_RK - 1)) begin
                        eng_state <= ENG_HOLD;
                    end
                end
                ENG_HOLD: begin
                    if (core_ready_i) begin
                        eng_state <= ENG_IDLE;
                    end
                end
                default: begin
                    if (blk_fire) begin
                        eng_state <= ENG_RUN;
                        rnd_cnt   <= '0;
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/present_result_buffer.sv */
// ========================================================================
// One-entry output slice. Holds its data until out_ready_i is seen.
// ========================================================================
module present_result_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid_i,
    input  present_pkg::block_t in_data_i,
    input  logic                out_ready_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output present_pkg::block_t out_data_o
);
    import present_pkg::*;

    logic   full;
    block_t data_q;

    // a leaving entry frees the slot in the same cycle.
    assign in_ready_o  = !full || out_ready_i;
    assign out_valid_o = full;
    assign out_data_o  = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            full <= 1'b1;
        end else if (out_ready_i) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

endmodule

/* hdl/present_top.sv */
// ========================================================================
// PRESENT-80 core. Keep blk_valid_i low while offering a new key, since
// both handshakes can complete in the same cycle when the engine is idle.
// ========================================================================
module present_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                key_valid_i,
    input  present_pkg::key_t   key_i,
    input  logic                blk_valid_i,
    input  present_pkg::block_t blk_i,
    input  logic                dec_i,
    input  logic                res_ready_i,
    output logic                key_ready_o,
    output logic                key_done_o,
    output logic                blk_ready_o,
    output logic                res_valid_o,
    output present_pkg::block_t res_o
);
    import present_pkg::*;

    // round-key lookup between engine and schedule.
    rk_idx_t rk_idx;
    block_t  rk;
    logic    engine_idle;

    // engine to result buffer.
    logic    core_valid;
    logic    core_ready;
    block_t  core_data;

    present_key_schedule key_schedule_i (
        .clk           (clk),
        .rst           (rst),
        .key_valid_i   (key_valid_i),
        .key_i         (key_i),
        .engine_idle_i (engine_idle),
        .rk_idx_i      (rk_idx),
        .key_ready_o   (key_ready_o),
        .key_done_o    (key_done_o),
        .rk_o          (rk)
    );

    present_round_engine round_engine_i (
        .clk          (clk),
        .rst          (rst),
        .blk_valid_i  (blk_valid_i),
        .blk_i        (blk_i),
        .dec_i        (dec_i),
        .keys_done_i  (key_done_o),
        .rk_i         (rk),
        .core_ready_i (core_ready),
        .blk_ready_o  (blk_ready_o),
        .idle_o       (engine_idle),
        .rk_idx_o     (rk_idx),
        .core_valid_o (core_valid),
        .core_data_o  (core_data)
    );

    present_result_buffer result_buffer_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (core_valid),
        .in_data_i   (core_data),
        .out_ready_i (res_ready_i),
        .in_ready_o  (core_ready),
        .out_valid_o (res_valid_o),
        .out_data_o  (res_o)
    );

endmodule

/* tb/present_tb.sv */
// ========================================================================
// Stimulus changes on falling edges. Results are compared on rising edges.
// ========================================================================
`include "present_params.svh"

module present_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import present_pkg::*;

    localparam int HS_TIMEOUT    = 500;
    localparam int KEY_TIMEOUT   = 100;
    localparam int DRAIN_TIMEOUT = 5000;
    localparam int NUM_RAND      = 20;
    localparam int BP_SLOT       = 24;  // cycles that one back-pressure pattern bit lasts.

    logic        clk;
    logic        rst;
    logic        key_valid_i;
    key_t        key_i;
    logic        blk_valid_i;
    block_t      blk_i;
    logic        dec_i;
    logic        res_ready_i;
    logic        key_ready_o;
    logic        key_done_o;
    logic        blk_ready_o;
    logic        res_valid_o;
    block_t      res_o;

    integer      seed;
    int          err_value;
    int          err_other;
    int          n_accepted;
    int          n_received;
    logic        bp_en;
    logic [31:0] bp_pattern;
    int          bp_cnt;
    logic        hold_q;
    block_t      hold_data_q;
    key_t        cur_key;
    block_t      exp_q[$];
    block_t      got_q[$];
    block_t      ct_list[$];
    block_t      pt_list[NUM_RAND];
    logic        dir_list[NUM_RAND];

    present_top present_top_i (
        .clk         (clk),
        .rst         (rst),
        .key_valid_i (key_valid_i),
        .key_i       (key_i),
        .blk_valid_i (blk_valid_i),
        .blk_i       (blk_i),
        .dec_i       (dec_i),
        .res_ready_i (res_ready_i),
        .key_ready_o (key_ready_o),
        .key_done_o  (key_done_o),
        .blk_ready_o (blk_ready_o),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ====================================================================
    // reference model, written from the cipher specification
    // ====================================================================
    function automatic logic [3:0] ref_sbox(logic [3:0] x);
        logic [63:0] tab;
        tab = 64'h21748FE3DA09B65C;  // nibble x holds S[x].
        return tab[{x, 2'b00} +: 4];
    endfunction

    function automatic logic [3:0] ref_sbox_inv(logic [3:0] y);
        logic [3:0] x;
        x = '0;
        for (int v = 0; v < 16; v++) begin
            if (ref_sbox(4'(v)) == y) begin
                x = 4'(v);
            end
        end
        return x;
    endfunction

    function automatic block_t ref_sub(block_t b, logic inv);
        block_t res;
        for (int n = 0; n < 16; n++) begin
            res[n*4 +: 4] = inv ? ref_sbox_inv(b[n*4 +: 4]) : ref_sbox(b[n*4 +: 4]);
        end
        return res;
    endfunction

    function automatic block_t ref_perm(block_t b, logic inv);
        block_t res;
        int     pos;
        for (int i = 0; i < `PRESENT_BLOCK_W; i++) begin
            pos = (i == 63) ? 63 : (i * 16) % 63;
            if (inv) begin
                res[i] = b[pos];
            end else begin
                res[pos] = b[i];
            end
        end
        return res;
    endfunction

    function automatic key_t ref_key_update(key_t k, int n);
        key_t t;
        t = {k[18:0], k[79:19]};
        t[79:76] = ref_sbox(t[79:76]);
        t[19:15] = t[19:15] ^ 5'(n);
        return t;
    endfunction

    function automatic block_t present_ref_enc(key_t key, block_t pt);
        block_t rk [`PRESENT_NUM_RK];
        key_t   k;
        block_t s;
        k = key;
        for (int r = 0; r < `PRESENT_NUM_RK; r++) begin
            rk[r] = k[79:16];
            k = ref_key_update(k, r + 1);
        end
        s = pt;
        for (int r = 0; r < `PRESENT_NUM_RK - 1; r++) begin
            s = ref_perm(ref_sub(s ^ rk[r], 1'b0), 1'b0);
        end
        return s ^ rk[`PRESENT_NUM_RK-1];
    endfunction

    function automatic block_t present_ref_dec(key_t key, block_t ct);
        block_t rk [`PRESENT_NUM_RK];
        key_t   k;
        block_t s;
        k = key;
        for (int r = 0; r < `PRESENT_NUM_RK; r++) begin
            rk[r] = k[79:16];
            k = ref_key_update(k, r + 1);
        end
        s = ct ^ rk[`PRESENT_NUM_RK-1];
        for (int r = `PRESENT_NUM_RK - 2; r >= 0; r--) begin
            s = ref_sub(ref_perm(s, 1'b1), 1'b1) ^ rk[r];
        end
        return s;
    endfunction

    // ====================================================================
    // checks and run control
    // ====================================================================
    task automatic check_block(string name, block_t got, block_t exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic end_run();
        $display("checks done: %0d value errors, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("Timeout: %s did not arrive in time.", what);
        err_other++;
        end_run();
    endtask

    function automatic block_t rand_block();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic key_t rand_key();
        block_t hi;
        block_t lo;
        hi = rand_block();
        lo = rand_block();
        return {hi, lo[63:48]};
    endfunction

    function automatic logic rand_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    // ====================================================================
    // drivers
    // ====================================================================
    task automatic load_key(key_t k);
        int n;
        n = 0;
        @(negedge clk);
        key_valid_i = 1'b1;
        key_i       = k;
        while (!key_ready_o) begin
            n++;
            if (n > HS_TIMEOUT) report_timeout("key_ready_o");
            @(negedge clk);
        end
        cur_key = k;
        @(negedge clk);
        key_valid_i = 1'b0;
        n = 0;
        check_bit("key_done_o", key_done_o, 1'b0);
        while (!key_done_o) begin
            if (n > KEY_TIMEOUT) report_timeout("key_done_o");
            @(negedge clk);
            n++;
        end
        if (n != `PRESENT_NUM_RK + 1) begin
            $display("Error: key_done_o latency got %h expected %h", n, `PRESENT_NUM_RK + 1);
            err_value++;
        end
        check_bit("blk_ready_o", blk_ready_o, 1'b1);
    endtask

    task automatic send_block(block_t data, logic dec, block_t exp);
        int waited;
        waited = 0;
        @(negedge clk);
        blk_valid_i = 1'b1;
        blk_i       = data;
        dec_i       = dec;
        while (!blk_ready_o) begin
            waited++;
            if (waited > HS_TIMEOUT) report_timeout("blk_ready_o");
            @(negedge clk);
        end
        exp_q.push_back(exp);  // taken at the coming rising edge.
        @(negedge clk);
        blk_valid_i = 1'b0;
    endtask

    task automatic send_random(int count);
        block_t pt;
        logic   dec;
        for (int i = 0; i < count; i++) begin
            pt  = rand_block();
            dec = rand_bit();
            if (i < NUM_RAND) begin
                pt_list[i]  = pt;
                dir_list[i] = dec;
            end
            send_block(pt, dec, dec ? present_ref_dec(cur_key, pt) : present_ref_enc(cur_key, pt));
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || res_valid_o) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) report_timeout("the last result");
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (bp_en) begin
            res_ready_i = bp_pattern[0];
            bp_cnt++;
            if (bp_cnt == BP_SLOT) begin
                bp_cnt     = 0;
                bp_pattern = {bp_pattern[0], bp_pattern[31:1]};
            end
        end else begin
            res_ready_i = 1'b1;
        end
    end

    // ====================================================================
    // result monitor
    // ====================================================================
    always @(posedge clk) begin
        if (!rst) begin
            // one block in the engine and one in the buffer fill the core.
            if (n_accepted - n_received == 2) begin
                check_bit("blk_ready_o", blk_ready_o, 1'b0);
                check_bit("key_ready_o", key_ready_o, 1'b0);
            end
            if (hold_q) begin
                check_bit("res_valid_o", res_valid_o, 1'b1);
                check_block("res_o", res_o, hold_data_q);
            end
            if (blk_valid_i && blk_ready_o) n_accepted++;
            if (res_valid_o && res_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out with no block expected.");
                    err_other++;
                end else begin
                    check_block("res_o", res_o, exp_q.pop_front());
                    got_q.push_back(res_o);
                end
                n_received++;
            end
            hold_q      = res_valid_o && !res_ready_i;
            hold_data_q = res_o;
        end
    end

    initial begin
        seed = 56;
        err_value = 0;
        err_other = 0;
        n_accepted = 0;
        n_received = 0;
        hold_q = 1'b0;
        bp_en = 1'b0;
        bp_cnt = 0;
        // the first three slots are low, so the second block finishes behind a full buffer.
        bp_pattern = $random(seed) & 32'h6DB6DB68;
        key_valid_i = 1'b0;
        key_i = '0;
        blk_valid_i = 1'b0;
        blk_i = '0;
        dec_i = 1'b0;
        res_ready_i = 1'b1;
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check_bit("key_done_o", key_done_o, 1'b0);
        check_bit("blk_ready_o", blk_ready_o, 1'b0);
        check_bit("res_valid_o", res_valid_o, 1'b0);
        check_bit("key_ready_o", key_ready_o, 1'b1);

        // published test vectors, also run through the reference model.
        check_block("ref_vector_0", present_ref_enc('0, '0), 64'h5579C1387B228445);
        check_block("ref_vector_1", present_ref_enc('1, '0), 64'hE72C46C0F5945049);
        load_key('0);
        send_block('0, 1'b0, 64'h5579C1387B228445);
        send_block('1, 1'b0, 64'hA112FFC72F68417B);
        wait_drain();
        load_key('1);
        send_block('0, 1'b0, 64'hE72C46C0F5945049);
        send_block('1, 1'b0, 64'h3333DCD3213210D2);
        wait_drain();

        load_key(rand_key());
        got_q.delete();
        send_random(NUM_RAND);
        wait_drain();

        // each result goes back in the other direction.
        ct_list = got_q;
        for (int i = 0; i < NUM_RAND; i++) begin
            send_block(ct_list[i], !dir_list[i], pt_list[i]);
        end
        wait_drain();

        @(posedge clk);
        bp_en = 1'b1;
        send_random(NUM_RAND);
        wait_drain();
        @(posedge clk);
        bp_en = 1'b0;

        load_key(rand_key());
        send_random(8);
        wait_drain();
        end_run();
    end

endmodule

/* flist.f */
+incdir+include
hdl/present_pkg.sv
hdl/present_key_schedule.sv
hdl/present_round_engine.sv
hdl/present_result_buffer.sv
hdl/present_top.sv
tb/present_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the PRESENT-80 testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module present_tb -f flist.f -Mdir obj_dir -o present_sim \
    && ./obj_dir/present_sim 2>&1 | tee sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
